// File: t07_pkg.sv
package t07_pkg;

    // cpu request opcode, same codes as the core's rwi lines
    typedef enum logic [1:0] {
        rwi_idle  = 2'b00, // nothing this cycle
        rwi_write = 2'b01, // store
        rwi_read  = 2'b10, // load
        rwi_fetch = 2'b11  // instruction fetch
    } rwi_e;

    // address map, cpu side
    localparam logic [31:0] instr_top = 32'd1024; // fetch region, inclusive
    localparam logic [31:0] data_low  = 32'd1056; // data region starts above this
    localparam logic [31:0] data_top  = 32'd1792; // data region end, inclusive
    localparam logic [31:0] disp_top  = 32'd2048; // display region end, exclusive

    localparam logic [7:0] bus_prefix = 8'h33; // top byte of every bus address

    // request from a bus master (mmio or host loader)
    typedef struct packed {
        logic        read;  // read strobe, held level
        logic        write; // write strobe, held level
        logic [31:0] addr;
        logic [31:0] data;  // store data
    } bus_req_t;

    // wishbone manager to subordinate
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_m2s_t;

    // wishbone subordinate to manager
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

    typedef enum logic [1:0] {
        wbm_idle,  // waiting for a strobe
        wbm_cycle, // cyc/stb out, waiting for ack
        wbm_done   // busy falls, edge pulse
    } wbm_state_e;

    typedef enum logic [1:0] {
        spi_idle,     // cs high, sclk low
        spi_shift_lo, // sclk low half
        spi_shift_hi  // sclk high half
    } spi_state_e;

endpackage

// File: t07_mmio.sv
`timescale 1ns/10ps

module t07_mmio (
    // cpu side
    input  logic [31:0]       addr_i,       // byte-free word address from the core
    input  t07_pkg::rwi_e     rwi_i,        // idle / write / read / fetch
    input  logic [31:0]       mem_data_i,   // store data from the core
    output logic [31:0]       instr_o,      // fetched word
    output logic [31:0]       cpu_data_o,   // load data back to the core
    output logic              cpu_busy_o,   // stall the core

    // bus side, through the arbiter
    input  logic [31:0]       wb_data_i,    // read data held by the manager
    input  logic              wb_busy_i,
    input  logic              wb_busy_edge_i,
    output t07_pkg::bus_req_t bus_req_o,

    // display side
    input  logic              spi_busy_i,
    input  logic [31:0]       spi_data_i,   // last word shifted in
    output logic [31:0]       disp_data_o,
    output logic              disp_write_o
);

    logic        in_instr; // fetch region hit
    logic        in_data;  // data memory hit
    logic        in_disp;  // display register hit
    logic [31:0] bus_addr; // address as seen on the bus

    assign in_instr = addr_i <= t07_pkg::instr_top;
    assign in_data  = (addr_i > t07_pkg::data_low) && (addr_i <= t07_pkg::data_top);
    assign in_disp  = (addr_i > t07_pkg::data_top) && (addr_i < t07_pkg::disp_top);
    assign bus_addr = {t07_pkg::bus_prefix, addr_i[23:0]}; // top byte replaced

    assign cpu_busy_o = wb_busy_i | spi_busy_i; // either side stalls the core

    always_comb begin
        // defaults for anything unmapped or unused
        instr_o         = 32'hdeadbeef;
        cpu_data_o      = 32'hdeadbeef;
        bus_req_o.read  = 1'b0;
        bus_req_o.write = 1'b0;
        bus_req_o.addr  = 32'hdeadbeef;
        bus_req_o.data  = 32'hdeadbeef;
        disp_data_o     = 32'hdeadbeef;
        disp_write_o    = 1'b0;

        case (rwi_i)
            t07_pkg::rwi_fetch: begin
                if (in_instr) begin
                    bus_req_o.read = ~wb_busy_edge_i; // no reissue on the edge
                    bus_req_o.addr = bus_addr;
                    instr_o        = wb_data_i;
                end
            end
            t07_pkg::rwi_read: begin
                if (in_data) begin
                    bus_req_o.read = ~wb_busy_edge_i;
                    bus_req_o.addr = bus_addr;
                    cpu_data_o     = wb_data_i; // valid on busy_edge
                end else if (in_disp) begin
                    cpu_data_o = spi_data_i; // word captured by the last transfer
                end
            end
            t07_pkg::rwi_write: begin
                if (in_data) begin
                    bus_req_o.write = ~wb_busy_edge_i;
                    bus_req_o.addr  = bus_addr;
                    bus_req_o.data  = mem_data_i;
                end else if (in_disp) begin
                    disp_write_o = ~wb_busy_edge_i; // spi takes it only while idle
                    disp_data_o  = mem_data_i;
                end
            end
            default: begin
                // idle, outputs keep their defaults
            end
        endcase
    end

endmodule

// File: t07_bus_arbiter.sv
`timescale 1ns/10ps

module t07_bus_arbiter (
    input  logic              clk,
    input  logic              reset_i,
    input  t07_pkg::bus_req_t cpu_req_i,       // from the mmio decoder
    input  t07_pkg::bus_req_t host_req_i,      // from the program loader
    input  logic              mgr_busy_i,
    input  logic              mgr_busy_edge_i,
    output t07_pkg::bus_req_t mgr_req_o,       // owner's request
    output logic              cpu_busy_o,
    output logic              cpu_busy_edge_o,
    output logic              host_busy_o
);

    logic locked_q;   // an owner holds the manager
    logic host_own_q; // 1 host, 0 cpu
    logic host_pend;  // host wants a transfer
    logic cpu_pend;   // cpu wants a transfer
    logic mgr_idle;   // manager can accept this cycle
    logic pick_host;  // mux select toward the manager
    logic host_grant; // host is the locked owner
    logic cpu_grant;  // cpu is the locked owner

    assign host_pend = host_req_i.read | host_req_i.write;
    assign cpu_pend  = cpu_req_i.read | cpu_req_i.write;
    assign mgr_idle  = ~mgr_busy_i & ~mgr_busy_edge_i;

    assign pick_host  = locked_q ? host_own_q : host_pend; // host first when free
    assign host_grant = locked_q & host_own_q;
    assign cpu_grant  = locked_q & ~host_own_q;

    assign mgr_req_o = pick_host ? host_req_i : cpu_req_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            locked_q   <= 1'b0;
            host_own_q <= 1'b0;
        end else if (locked_q) begin
            if (mgr_busy_edge_i) locked_q <= 1'b0; // release after the edge pulse
        end else if (mgr_idle && (host_pend || cpu_pend)) begin
            locked_q   <= 1'b1;      // manager accepts this cycle
            host_own_q <= host_pend; // same choice as the mux
        end
    end

    // owner follows the manager, a waiting requester sees busy
    assign cpu_busy_o      = cpu_grant ? mgr_busy_i : cpu_pend;
    assign host_busy_o     = host_grant ? mgr_busy_i : host_pend;
    assign cpu_busy_edge_o = cpu_grant & mgr_busy_edge_i; // only the owner gets it

endmodule

// File: t07_wb_manager.sv
`timescale 1ns/10ps

module t07_wb_manager (
    input  logic              clk,
    input  logic              reset_i,
    input  t07_pkg::bus_req_t req_i,       // granted request from the arbiter
    input  t07_pkg::wb_s2m_t  wb_i,        // ack and read data
    output t07_pkg::wb_m2s_t  wb_o,
    output logic              busy_o,      // high while the cycle runs
    output logic              busy_edge_o, // one pulse as busy falls
    output logic [31:0]       rdata_o      // last word read
);

    t07_pkg::wbm_state_e state_q;
    t07_pkg::wbm_state_e state_d;

    logic        strobe;  // read or write wanted
    logic [31:0] adr_q;   // latched on accept
    logic [31:0] dat_q;   // store data
    logic        we_q;    // direction of this cycle
    logic [31:0] rdata_q; // held until the next read

    assign strobe = req_i.read | req_i.write;

    always_comb begin
        state_d = state_q;
        case (state_q)
            t07_pkg::wbm_idle: begin
                if (strobe) state_d = t07_pkg::wbm_cycle; // cycle 0 accept
            end
            t07_pkg::wbm_cycle: begin
                if (wb_i.ack) state_d = t07_pkg::wbm_done; // ack in cycle 2
            end
            t07_pkg::wbm_done: begin
                state_d = t07_pkg::wbm_idle; // edge cycle, back to idle
            end
            default: begin
                state_d = t07_pkg::wbm_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= t07_pkg::wbm_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == t07_pkg::wbm_idle && strobe) begin
            adr_q <= req_i.addr;
            dat_q <= req_i.data;
            we_q  <= req_i.write; // write wins if both are high
        end
        if (state_q == t07_pkg::wbm_cycle && wb_i.ack && !we_q) begin
            rdata_q <= wb_i.dat; // ready in the busy_edge cycle
        end
    end

    // cyc and stb stay up from cycle 1 until ack
    assign wb_o.cyc = (state_q == t07_pkg::wbm_cycle);
    assign wb_o.stb = (state_q == t07_pkg::wbm_cycle);
    assign wb_o.we  = we_q;
    assign wb_o.adr = adr_q;
    assign wb_o.dat = dat_q;

    assign busy_o      = (state_q == t07_pkg::wbm_cycle);
    assign busy_edge_o = (state_q == t07_pkg::wbm_done);
    assign rdata_o     = rdata_q;

endmodule

// File: t07_wb_sram.sv
`timescale 1ns/10ps

module t07_wb_sram #(
    parameter int unsigned mem_words = 2048 // depth in 32-bit words
) (
    input  logic             clk,
    input  logic             reset_i,
    input  t07_pkg::wb_m2s_t wb_i,
    output t07_pkg::wb_s2m_t wb_o
);

    localparam int unsigned aw = $clog2(mem_words); // index width

    logic [31:0]   mem [mem_words]; // word array
    logic [aw-1:0] idx;             // word index from the bus address
    logic          access;          // new request this cycle
    logic          ack_q;
    logic [31:0]   rdat_q;

    // prefix byte dropped, wraps modulo the depth
    assign idx = aw'(wb_i.adr[23:0] % mem_words);

    // one access per cycle, not repeated while ack is out
    assign access = wb_i.cyc & wb_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access; // one cycle after stb
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_i.we) begin
                mem[idx] <= wb_i.dat;
            end else begin
                rdat_q <= mem[idx];
            end
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdat_q;

endmodule

// File: t07_spi_tft.sv
`timescale 1ns/10ps

module t07_spi_tft #(
    parameter int unsigned spi_bits = 32 // transfer length, at most 32
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        write_i,  // display store from the decoder
    input  logic [31:0] data_i,
    input  logic        miso_i,
    output logic        busy_o,
    output logic [31:0] rdata_o,  // bits captured by the last transfer
    output logic        sclk_o,
    output logic        cs_o,     // active low
    output logic        mosi_o
);

    t07_pkg::spi_state_e state_q;

    logic [5:0]  bit_q;  // bits sent so far
    logic [31:0] tx_q;   // msb goes out first
    logic [31:0] rx_q;   // shifts in from the right
    logic        sclk_q;
    logic        cs_q;
    logic [31:0] rdata_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= t07_pkg::spi_idle;
            sclk_q  <= 1'b0;
            cs_q    <= 1'b1; // deselected
            rdata_q <= 32'd0;
            bit_q   <= 6'd0;
        end else begin
            case (state_q)
                t07_pkg::spi_idle: begin
                    if (write_i) begin
                        state_q <= t07_pkg::spi_shift_lo;
                        cs_q    <= 1'b0;
                        bit_q   <= 6'd0;
                    end
                end
                t07_pkg::spi_shift_lo: begin
                    sclk_q  <= 1'b1; // rising edge, both sides sample
                    state_q <= t07_pkg::spi_shift_hi;
                end
                t07_pkg::spi_shift_hi: begin
                    sclk_q <= 1'b0; // falling edge, next bit goes out
                    if (bit_q == 6'(spi_bits - 1)) begin
                        state_q <= t07_pkg::spi_idle;
                        cs_q    <= 1'b1;
                        rdata_q <= rx_q; // whole word in
                    end else begin
                        bit_q   <= bit_q + 6'd1;
                        state_q <= t07_pkg::spi_shift_lo;
                    end
                end
                default: begin
                    state_q <= t07_pkg::spi_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == t07_pkg::spi_idle && write_i) begin
            tx_q <= data_i << (32 - spi_bits); // left aligned
            rx_q <= 32'd0;
        end else if (state_q == t07_pkg::spi_shift_lo) begin
            rx_q <= {rx_q[30:0], miso_i}; // sample with sclk rising
        end else if (state_q == t07_pkg::spi_shift_hi) begin
            tx_q <= {tx_q[30:0], 1'b0};
        end
    end

    assign busy_o  = (state_q != t07_pkg::spi_idle);
    assign sclk_o  = sclk_q;
    assign cs_o    = cs_q;
    assign mosi_o  = ~cs_q & tx_q[31]; // quiet low while deselected
    assign rdata_o = rdata_q;

endmodule

// File: t07_mmio_top.sv
`timescale 1ns/10ps

module t07_mmio_top #(
    parameter int unsigned mem_words = 2048, // sram depth
    parameter int unsigned spi_bits  = 32    // display transfer length
) (
    input  logic              clk,
    input  logic              reset_i,
    // cpu
    input  logic [31:0]       addr_i,
    input  t07_pkg::rwi_e     rwi_i,
    input  logic [31:0]       mem_data_i,
    output logic [31:0]       instr_o,
    output logic [31:0]       cpu_data_o,
    output logic              cpu_busy_o,
    // program loader
    input  t07_pkg::bus_req_t host_req_i,
    output logic              host_busy_o,
    output logic [31:0]       host_data_o,
    // display pins
    output logic              tft_sclk_o,
    output logic              tft_cs_o,
    output logic              tft_mosi_o,
    input  logic              tft_miso_i
);

    t07_pkg::bus_req_t cpu_req;      // decoder to arbiter
    t07_pkg::bus_req_t mgr_req;      // arbiter to manager
    t07_pkg::wb_m2s_t  wb_m2s;
    t07_pkg::wb_s2m_t  wb_s2m;
    logic              cpu_bus_busy; // cpu view of the bus
    logic              cpu_bus_edge;
    logic              mgr_busy;
    logic              mgr_edge;
    logic [31:0]       mgr_rdata;    // shared by cpu and host
    logic [31:0]       disp_data;
    logic              disp_write;
    logic              spi_busy;
    logic [31:0]       spi_rdata;

    assign host_data_o = mgr_rdata;

    t07_mmio u_mmio (
        .addr_i(addr_i), .rwi_i(rwi_i), .mem_data_i(mem_data_i), .instr_o(instr_o),
        .cpu_data_o(cpu_data_o), .cpu_busy_o(cpu_busy_o), .wb_data_i(mgr_rdata),
        .wb_busy_i(cpu_bus_busy), .wb_busy_edge_i(cpu_bus_edge), .bus_req_o(cpu_req),
        .spi_busy_i(spi_busy), .spi_data_i(spi_rdata), .disp_data_o(disp_data),
        .disp_write_o(disp_write));

    t07_bus_arbiter u_arb (
        .clk(clk), .reset_i(reset_i), .cpu_req_i(cpu_req), .host_req_i(host_req_i),
        .mgr_busy_i(mgr_busy), .mgr_busy_edge_i(mgr_edge), .mgr_req_o(mgr_req),
        .cpu_busy_o(cpu_bus_busy), .cpu_busy_edge_o(cpu_bus_edge), .host_busy_o(host_busy_o));

    t07_wb_manager u_wbm (
        .clk(clk), .reset_i(reset_i), .req_i(mgr_req), .wb_i(wb_s2m), .wb_o(wb_m2s),
        .busy_o(mgr_busy), .busy_edge_o(mgr_edge), .rdata_o(mgr_rdata));

    t07_wb_sram #(.mem_words(mem_words)) u_sram (
        .clk(clk), .reset_i(reset_i), .wb_i(wb_m2s), .wb_o(wb_s2m));

    t07_spi_tft #(.spi_bits(spi_bits)) u_spi (
        .clk(clk), .reset_i(reset_i), .write_i(disp_write), .data_i(disp_data),
        .miso_i(tft_miso_i), .busy_o(spi_busy), .rdata_o(spi_rdata), .sclk_o(tft_sclk_o),
        .cs_o(tft_cs_o), .mosi_o(tft_mosi_o));

endmodule

// File: tb_t07_mmio.sv
`timescale 1ns/10ps

module tb_t07_mmio;

    localparam int unsigned mem_words = 2048; // sram depth seen by the model
    localparam int unsigned spi_bits  = 32;

    logic              clk;
    logic              reset_i;
    logic [31:0]       addr_i;
    t07_pkg::rwi_e     rwi_i;
    logic [31:0]       mem_data_i;
    logic [31:0]       instr_o;
    logic [31:0]       cpu_data_o;
    logic              cpu_busy_o;
    t07_pkg::bus_req_t host_req_i;
    logic              host_busy_o;
    logic [31:0]       host_data_o;
    logic              tft_sclk_o;
    logic              tft_cs_o;
    logic              tft_mosi_o;
    logic              tft_miso_i;

    int          seed;
    logic [31:0] model_mem [int unsigned]; // reference memory by word index
    logic [31:0] disp_word;                // last word sent to the panel
    string       name_q [$];               // results waiting for the compare process
    logic [31:0] act_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] instr_list [$];           // fetch addresses loaded by the host
    logic [31:0] data_list [$];            // data addresses stored by the cpu
    logic [31:0] unmapped_list [6];        // gap and above the display
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] rd;
    logic [31:0] rd2;
    int          cyc;
    int          cyc2;

    t07_mmio_top #(.mem_words(mem_words), .spi_bits(spi_bits)) dut (
        .clk(clk), .reset_i(reset_i), .addr_i(addr_i), .rwi_i(rwi_i),
        .mem_data_i(mem_data_i), .instr_o(instr_o), .cpu_data_o(cpu_data_o),
        .cpu_busy_o(cpu_busy_o), .host_req_i(host_req_i), .host_busy_o(host_busy_o),
        .host_data_o(host_data_o), .tft_sclk_o(tft_sclk_o), .tft_cs_o(tft_cs_o),
        .tft_mosi_o(tft_mosi_o), .tft_miso_i(tft_miso_i));

    assign tft_miso_i = tft_mosi_o; // panel loopback

    always #5 clk = ~clk; // 10 ns period

    // expected read value straight from the address map
    function automatic logic [31:0] ref_read(input t07_pkg::rwi_e op, input logic [31:0] addr);
        int unsigned idx;
        idx = addr[23:0] % mem_words; // bus drops the top byte
        if (op == t07_pkg::rwi_fetch && addr <= 32'd1024) begin
            return model_mem.exists(idx) ? model_mem[idx] : 32'hx;
        end else if (op == t07_pkg::rwi_read && addr > 32'd1056 && addr <= 32'd1792) begin
            return model_mem.exists(idx) ? model_mem[idx] : 32'hx;
        end else if (op == t07_pkg::rwi_read && addr > 32'd1792 && addr < 32'd2048) begin
            return disp_word; // loopback gives back the last word sent
        end
        return 32'hdeadbeef; // gap and above the display
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s did not fall within 200 cycles", $time, what);
        $display("TEST FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic expect_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        name_q.push_back(name);
        act_q.push_back(actual);
        exp_q.push_back(expected);
    endtask

    // compare process, drains whatever the drivers queued
    always @(posedge clk) begin
        while (act_q.size() > 0) begin
            check(name_q.pop_front(), act_q.pop_front(), exp_q.pop_front());
        end
    end

    // cpu request held until busy falls, then dropped
    task automatic cpu_access(input t07_pkg::rwi_e op, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int cycles);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        rwi_i      = op;
        addr_i     = addr;
        mem_data_i = wdata;
        @(negedge clk);
        while (cpu_busy_o) begin
            n++;
            if (n >= 200) report_timeout("cpu_busy_o");
            @(negedge clk);
        end
        rdata  = (op == t07_pkg::rwi_fetch) ? instr_o : cpu_data_o; // valid on the edge cycle
        cycles = n;
        @(posedge clk);
        #1;
        rwi_i = t07_pkg::rwi_idle; // gone before the next decision
    endtask

    task automatic host_access(input logic wr, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int cycles);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        host_req_i.read  = ~wr;
        host_req_i.write = wr;
        host_req_i.addr  = {8'h33, addr[23:0]}; // loader uses bus addresses
        host_req_i.data  = wdata;
        @(negedge clk);
        while (host_busy_o) begin
            n++;
            if (n >= 200) report_timeout("host_busy_o");
            @(negedge clk);
        end
        rdata  = host_data_o;
        cycles = n;
        @(posedge clk);
        #1;
        host_req_i = '0;
    endtask

    // one-cycle display store, then wait for the shift to finish
    task automatic display_write(input logic [31:0] addr, input logic [31:0] wdata);
        int   n;
        int   rises;     // sclk rising edges seen during the transfer
        logic sclk_prev;
        n     = 0;
        rises = 0;
        @(posedge clk);
        #1;
        rwi_i      = t07_pkg::rwi_write;
        addr_i     = addr;
        mem_data_i = wdata;
        @(posedge clk);
        #1;
        rwi_i = t07_pkg::rwi_idle;
        @(negedge clk);
        check("tft_cs_o", tft_cs_o, 1'b0);
        check("cpu_busy_o", cpu_busy_o, 1'b1);
        sclk_prev = tft_sclk_o;
        while (cpu_busy_o) begin
            n++;
            if (n >= 200) report_timeout("cpu_busy_o during spi");
            @(negedge clk);
            if (tft_sclk_o && !sclk_prev) rises++;
            sclk_prev = tft_sclk_o;
        end
        check("tft_cs_o", tft_cs_o, 1'b1); // deselected again
        check("tft_sclk_o", tft_sclk_o, 1'b0); // clock parks low
        check("tft_sclk_o rising edges", rises, spi_bits); // one per bit
        disp_word = wdata;
    endtask

    // unmapped request, bus must stay quiet for a few cycles
    task automatic quiet_access(input t07_pkg::rwi_e op, input logic [31:0] addr);
        @(posedge clk);
        #1;
        rwi_i      = op;
        addr_i     = addr;
        mem_data_i = $random(seed);
        repeat (4) begin
            @(negedge clk);
            check("cpu_busy_o", cpu_busy_o, 1'b0);
        end
        if (op == t07_pkg::rwi_fetch) expect_value("instr_o", instr_o, ref_read(op, addr));
        if (op == t07_pkg::rwi_read) expect_value("cpu_data_o", cpu_data_o, ref_read(op, addr));
        @(posedge clk);
        #1;
        rwi_i = t07_pkg::rwi_idle;
    endtask

    initial begin
        seed       = 32'hf89e_3c43;
        clk        = 1'b0;
        reset_i    = 1'b1;
        addr_i     = 32'd0;
        rwi_i      = t07_pkg::rwi_idle;
        mem_data_i = 32'd0;
        host_req_i = '0;
        disp_word  = 32'd0;
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;

        // host loads the fetch region, word 0 and the top word included
        for (int i = 0; i < 8; i++) begin
            a = (i == 0) ? 32'd0 : (i == 1) ? 32'd1024 : {$random(seed)} % 1025;
            d = $random(seed);
            host_access(1'b1, a, d, rd, cyc);
            check("host_busy_o latency", cyc, 3);
            model_mem[a % mem_words] = d;
            instr_list.push_back(a);
        end
        foreach (instr_list[i]) begin
            host_access(1'b0, instr_list[i], 32'd0, rd, cyc);
            expect_value("host_data_o", rd, ref_read(t07_pkg::rwi_fetch, instr_list[i]));
            cpu_access(t07_pkg::rwi_fetch, instr_list[i], 32'd0, rd, cyc);
            expect_value("instr_o", rd, ref_read(t07_pkg::rwi_fetch, instr_list[i]));
            check("cpu_busy_o latency", cyc, 3);
        end

        // cpu stores and loads in the data region
        for (int i = 0; i < 8; i++) begin
            a = 32'd1057 + ({$random(seed)} % 736);
            d = $random(seed);
            cpu_access(t07_pkg::rwi_write, a, d, rd, cyc);
            check("cpu_busy_o latency", cyc, 3);
            model_mem[a % mem_words] = d;
            data_list.push_back(a);
        end
        foreach (data_list[i]) begin
            cpu_access(t07_pkg::rwi_read, data_list[i], 32'd0, rd, cyc);
            expect_value("cpu_data_o", rd, ref_read(t07_pkg::rwi_read, data_list[i]));
            check("cpu_busy_o latency", cyc, 3);
        end

        // display stores go out over spi and come back on the loopback
        a = 32'd1793 + ({$random(seed)} % 255);
        cpu_access(t07_pkg::rwi_read, a, 32'd0, rd, cyc);
        expect_value("cpu_data_o", rd, ref_read(t07_pkg::rwi_read, a));
        repeat (2) begin
            display_write(a, $random(seed));
            cpu_access(t07_pkg::rwi_read, a, 32'd0, rd, cyc);
            expect_value("cpu_data_o", rd, ref_read(t07_pkg::rwi_read, a));
        end

        // gap and above the display, 2048 would alias word 0 if it reached the bus
        unmapped_list = '{32'd1025, 32'd1040, 32'd1056, 32'd2048, 32'd4095, 32'h0010_0000};
        foreach (unmapped_list[i]) begin
            a = unmapped_list[i];
            quiet_access(t07_pkg::rwi_read, a);
            quiet_access(t07_pkg::rwi_fetch, a);
            quiet_access(t07_pkg::rwi_write, a);
        end
        cpu_access(t07_pkg::rwi_fetch, 32'd0, 32'd0, rd, cyc);
        expect_value("instr_o", rd, ref_read(t07_pkg::rwi_fetch, 32'd0));

        // host and cpu in the same cycle, host wins
        d = $random(seed);
        fork
            host_access(1'b1, 32'd512, d, rd, cyc);
            cpu_access(t07_pkg::rwi_read, data_list[0], 32'd0, rd2, cyc2);
        join
        check("host_busy_o latency", cyc, 3);
        check("cpu_busy_o held past host", cyc2 > cyc, 1'b1);
        model_mem[512] = d;
        expect_value("cpu_data_o", rd2, ref_read(t07_pkg::rwi_read, data_list[0]));
        cpu_access(t07_pkg::rwi_fetch, 32'd512, 32'd0, rd, cyc);
        expect_value("instr_o", rd, ref_read(t07_pkg::rwi_fetch, 32'd512));

        repeat (2) @(posedge clk); // let the compare process drain
        #1;
        if (act_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("results were left in the compare queue without being checked");
            $display("TEST FAILED");
            $fatal(1, "stopping on unchecked results");
        end
    end

endmodule

// File: build.f
t07_pkg.sv
t07_mmio.sv
t07_bus_arbiter.sv
t07_wb_manager.sv
t07_wb_sram.sv
t07_spi_tft.sv
t07_mmio_top.sv
tb_t07_mmio.sv

// File: Bender.yml
package:
  name: t07_mmio

sources:
  - t07_pkg.sv
  - t07_mmio.sv
  - t07_bus_arbiter.sv
  - t07_wb_manager.sv
  - t07_wb_sram.sv
  - t07_spi_tft.sv
  - t07_mmio_top.sv
  - target: test
    files:
      - tb_t07_mmio.sv
